/* hw/bus_pkg.sv */
// ----------------------------------------------------------
// memory map and bus types shared by the arbiter and peripherals
// regions are word aligned; sizes are in 32-bit words
// ----------------------------------------------------------
`default_nettype none

package bus_pkg;

	// ----------------------------------------------------------
	// memory map
	// ----------------------------------------------------------
	localparam logic [31:0] ROM_BASE   = 32'h0000_0000;
	localparam logic [31:0] RAM_BASE   = 32'h1000_0000;
	localparam logic [31:0] IO_BASE    = 32'hf020_0000;
	localparam logic [31:0] TIMER_BASE = 32'hf060_0000;

	// region sizes in words
	localparam int unsigned ROM_WORDS   = 16;
	localparam int unsigned RAM_WORDS   = 256;
	localparam int unsigned IO_WORDS    = 2;
	localparam int unsigned TIMER_WORDS = 1;

	// word index widths
	localparam int unsigned ROM_AW = $clog2(ROM_WORDS);
	localparam int unsigned RAM_AW = $clog2(RAM_WORDS);

	// byte offsets inside the io region
	localparam logic [31:0] IO_LEDS_OFS     = 32'h0000_0000;
	localparam logic [31:0] IO_SWITCHES_OFS = 32'h0000_0004;

	// ----------------------------------------------------------
	// bus types
	// ----------------------------------------------------------
	typedef enum logic [2:0] {
		sel_rom,
		sel_ram,
		sel_io,
		sel_timer,
		sel_none
	} mod_sel_t;

	// request into one peripheral, 99 bits
	typedef struct packed {
		logic        ie;
		logic        de;
		logic [31:0] iaddr;
		logic [31:0] daddr;
		logic        drw;
		logic [31:0] wdata;
	} bus_req_t;

	// reply from one peripheral, zero on a field whose enable is low
	typedef struct packed {
		logic [31:0] inst;
		logic [31:0] data;
	} bus_rsp_t;

endpackage

`default_nettype wire

/* hw/addr_map.sv */
// ----------------------------------------------------------
// purely combinational; unmatched addresses give sel_none, offset 0
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module addr_map (
	input  logic [31:0]      addr,
	output bus_pkg::mod_sel_t sel,
	output logic [31:0]      eff_addr
);

	// offsets from each region base
	logic [31:0] rom_ofs;
	logic [31:0] ram_ofs;
	logic [31:0] io_ofs;
	logic [31:0] timer_ofs;

	// wraps below the base, so one unsigned compare covers both ends
	assign rom_ofs   = addr - bus_pkg::ROM_BASE;
	assign ram_ofs   = addr - bus_pkg::RAM_BASE;
	assign io_ofs    = addr - bus_pkg::IO_BASE;
	assign timer_ofs = addr - bus_pkg::TIMER_BASE;

	always_comb begin
		sel      = bus_pkg::sel_none;
		eff_addr = '0;
		if (rom_ofs < 32'(bus_pkg::ROM_WORDS * 4)) begin
			sel      = bus_pkg::sel_rom;
			eff_addr = rom_ofs;
		end else if (ram_ofs < 32'(bus_pkg::RAM_WORDS * 4)) begin
			sel      = bus_pkg::sel_ram;
			eff_addr = ram_ofs;
		end else if (io_ofs < 32'(bus_pkg::IO_WORDS * 4)) begin
			sel      = bus_pkg::sel_io;
			eff_addr = io_ofs;
		end else if (timer_ofs < 32'(bus_pkg::TIMER_WORDS * 4)) begin
			sel      = bus_pkg::sel_timer;
			eff_addr = timer_ofs;
		end
	end

endmodule

`default_nettype wire

/* hw/mod_rom.sv */
// ----------------------------------------------------------
// contents come from hw/rom_init.mem, run from the project root
// bus writes are dropped
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mod_rom (
	input  logic              clk,
	input  logic              rst_n,
	input  bus_pkg::bus_req_t req,
	output bus_pkg::bus_rsp_t rsp
);

	logic [31:0] mem [bus_pkg::ROM_WORDS];

	initial begin
		$readmemh("hw/rom_init.mem", mem);
	end

	// two independent read ports
	assign rsp.inst = req.ie ? mem[req.iaddr[bus_pkg::ROM_AW+1:2]] : '0;
	assign rsp.data = req.de ? mem[req.daddr[bus_pkg::ROM_AW+1:2]] : '0;

	// software bug rather than a hardware fault, so only a warning
	a_no_rom_write: assert property (@(posedge clk) disable iff (!rst_n)
		!(req.de && req.drw))
		else $warning("write to rom ignored");

endmodule

`default_nettype wire

/* hw/mod_ram.sv */
// ----------------------------------------------------------
// word addressed; contents undefined after reset
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mod_ram (
	input  logic              clk,
	input  logic              rst_n,
	input  bus_pkg::bus_req_t req,
	output bus_pkg::bus_rsp_t rsp
);

	logic [31:0]                 mem [bus_pkg::RAM_WORDS];
	logic [bus_pkg::RAM_AW-1:0] iidx;
	logic [bus_pkg::RAM_AW-1:0] didx;

	// byte address down to word index
	assign iidx = req.iaddr[bus_pkg::RAM_AW+1:2];
	assign didx = req.daddr[bus_pkg::RAM_AW+1:2];

	// ----------------------------------------------------------
	// read ports
	// ----------------------------------------------------------
	assign rsp.inst = req.ie ? mem[iidx] : '0;
	assign rsp.data = req.de ? mem[didx] : '0;

	// ----------------------------------------------------------
	// write port
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (req.de && req.drw) begin
			mem[didx] <= req.wdata;
		end
	end

	// the decoder upstream should never pass an offset past the end
	a_iaddr_range: assert property (@(posedge clk) disable iff (!rst_n)
		req.ie |-> req.iaddr < bus_pkg::RAM_WORDS * 4)
		else $error("ram instruction address out of range");

	a_daddr_range: assert property (@(posedge clk) disable iff (!rst_n)
		req.de |-> req.daddr < bus_pkg::RAM_WORDS * 4)
		else $error("ram data address out of range");

endmodule

`default_nettype wire

/* hw/mod_io.sv */
// ----------------------------------------------------------
// leds word is read/write, switches word read-only; upper bits read 0
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mod_io (
	input  logic              clk,
	input  logic              rst_n,
	input  bus_pkg::bus_req_t req,
	output bus_pkg::bus_rsp_t rsp,
	output logic [7:0]        leds,
	input  logic [7:0]        switches
);

	// word seen at one offset
	function automatic logic [31:0] io_word(input logic [31:0] ofs,
	                                       input logic [7:0] led_val,
	                                       input logic [7:0] sw_val);
		logic [31:0] word;
		word = '0;
		if (ofs == bus_pkg::IO_LEDS_OFS)
			word = {24'b0, led_val};
		else if (ofs == bus_pkg::IO_SWITCHES_OFS)
			word = {24'b0, sw_val};
		return word;
	endfunction

	assign rsp.inst = req.ie ? io_word(req.iaddr, leds, switches) : '0;
	assign rsp.data = req.de ? io_word(req.daddr, leds, switches) : '0;

	// led register, only the low byte of wdata is kept
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			leds <= '0;
		end else if (req.de && req.drw && req.daddr == bus_pkg::IO_LEDS_OFS) begin
			leds <= req.wdata[7:0];
		end
	end

endmodule

`default_nettype wire

/* hw/mod_timer.sv */
// ----------------------------------------------------------
// free-running counter, wraps at 2^32; any offset in region hits it
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mod_timer (
	input  logic              clk,
	input  logic              rst_n,
	input  bus_pkg::bus_req_t req,
	output bus_pkg::bus_rsp_t rsp
);

	logic [31:0] count;
	logic        load;

	assign load = req.de && req.drw;

	// ----------------------------------------------------------
	// counter
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (load) begin
			// counting resumes from the loaded value next edge
			count <= req.wdata;
		end else begin
			count <= count + 32'd1;
		end
	end

	// ----------------------------------------------------------
	// read ports
	// ----------------------------------------------------------
	assign rsp.inst = req.ie ? count : '0;
	assign rsp.data = req.de ? count : '0;

endmodule

`default_nettype wire

/* hw/arbiter.sv */
// ----------------------------------------------------------
// reads are combinational and writes land on the clk edge; no stall
// cpu addresses must be word aligned
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module arbiter (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] iaddr,
	input  logic [31:0] daddr,
	input  logic [31:0] wdata,
	input  logic        drw,
	output logic [31:0] inst,
	output logic [31:0] rdata,
	output logic [7:0]  leds,
	input  logic [7:0]  switches
);

	bus_pkg::mod_sel_t isel, dsel;
	logic [31:0]       ieff_addr, deff_addr;

	bus_pkg::bus_req_t base_req;
	bus_pkg::bus_req_t rom_req, ram_req, io_req, timer_req;
	bus_pkg::bus_rsp_t rom_rsp, ram_rsp, io_rsp, timer_rsp;

	addr_map i_imap (.addr(iaddr), .sel(isel), .eff_addr(ieff_addr));
	addr_map i_dmap (.addr(daddr), .sel(dsel), .eff_addr(deff_addr));

	// ----------------------------------------------------------
	// per-module requests
	// ----------------------------------------------------------
	always_comb begin
		base_req       = '0;
		base_req.iaddr = ieff_addr;
		base_req.daddr = deff_addr;
		base_req.drw   = drw;
		base_req.wdata = wdata;

		rom_req      = base_req;
		rom_req.ie   = (isel == bus_pkg::sel_rom);
		rom_req.de   = (dsel == bus_pkg::sel_rom);
		ram_req      = base_req;
		ram_req.ie   = (isel == bus_pkg::sel_ram);
		ram_req.de   = (dsel == bus_pkg::sel_ram);
		io_req       = base_req;
		io_req.ie    = (isel == bus_pkg::sel_io);
		io_req.de    = (dsel == bus_pkg::sel_io);
		timer_req    = base_req;
		timer_req.ie = (isel == bus_pkg::sel_timer);
		timer_req.de = (dsel == bus_pkg::sel_timer);
	end

	mod_rom   i_rom   (.clk(clk), .rst_n(rst_n), .req(rom_req), .rsp(rom_rsp));
	mod_ram   i_ram   (.clk(clk), .rst_n(rst_n), .req(ram_req), .rsp(ram_rsp));
	mod_io    i_io    (.clk(clk), .rst_n(rst_n), .req(io_req), .rsp(io_rsp),
	                   .leds(leds), .switches(switches));
	mod_timer i_timer (.clk(clk), .rst_n(rst_n), .req(timer_req), .rsp(timer_rsp));

	// ----------------------------------------------------------
	// reply muxes, zero when nothing matched
	// ----------------------------------------------------------
	always_comb begin
		case (isel)
			bus_pkg::sel_rom:   inst = rom_rsp.inst;
			bus_pkg::sel_ram:   inst = ram_rsp.inst;
			bus_pkg::sel_io:    inst = io_rsp.inst;
			bus_pkg::sel_timer: inst = timer_rsp.inst;
			default:            inst = '0;
		endcase
	end

	always_comb begin
		case (dsel)
			bus_pkg::sel_rom:   rdata = rom_rsp.data;
			bus_pkg::sel_ram:   rdata = ram_rsp.data;
			bus_pkg::sel_io:    rdata = io_rsp.data;
			bus_pkg::sel_timer: rdata = timer_rsp.data;
			default:            rdata = '0;
		endcase
	end

	a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		iaddr[1:0] == 2'b00 && daddr[1:0] == 2'b00)
		else $error("cpu address not word aligned");

endmodule

`default_nettype wire

/* test/tb_arbiter.sv */
// ----------------------------------------------------------
// run from the project root; rom contents come from hw/rom_init.mem
// ram words are only checked once a write has defined them
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_arbiter;

	localparam int HALF_PERIOD = 4;
	localparam int PERIOD = 2 * HALF_PERIOD;

	logic        clk;
	logic        rst_n;
	logic [31:0] iaddr, daddr, wdata, inst, rdata;
	logic        drw;
	logic [7:0]  leds, switches;

	// reference state
	logic [31:0] rom_copy [bus_pkg::ROM_WORDS];
	logic [31:0] ram_model [bus_pkg::RAM_WORDS];
	bit          ram_valid [bus_pkg::RAM_WORDS];
	logic [7:0]  led_model;
	logic [31:0] timer_model;

	int          errors, checks, tests, errs_mark;
	bit          timed_out;
	logic [31:0] exp_inst, exp_rdata;
	bit          inst_known, rdata_known;

	arbiter i_arbiter (.clk(clk), .rst_n(rst_n), .iaddr(iaddr), .daddr(daddr),
		.wdata(wdata), .drw(drw), .inst(inst), .rdata(rdata), .leds(leds),
		.switches(switches));

	initial clk = 1'b0;
	always #HALF_PERIOD clk = ~clk;

	// ----------------------------------------------------------
	// reference model
	// ----------------------------------------------------------
	function automatic logic [31:0] ref_read(input logic [31:0] addr, output bit known);
		logic [31:0] word;
		int unsigned idx;
		word = '0;
		known = 1'b1;
		if (addr < bus_pkg::ROM_BASE + bus_pkg::ROM_WORDS * 4) begin
			idx = (addr - bus_pkg::ROM_BASE) >> 2;
			word = rom_copy[idx];
		end else if (addr >= bus_pkg::RAM_BASE &&
		             addr < bus_pkg::RAM_BASE + bus_pkg::RAM_WORDS * 4) begin
			idx = (addr - bus_pkg::RAM_BASE) >> 2;
			word = ram_model[idx];
			known = ram_valid[idx];
		end else if (addr == bus_pkg::IO_BASE + bus_pkg::IO_LEDS_OFS) begin
			word = {24'b0, led_model};
		end else if (addr == bus_pkg::IO_BASE + bus_pkg::IO_SWITCHES_OFS) begin
			word = {24'b0, switches};
		end else if (addr == bus_pkg::TIMER_BASE) begin
			word = timer_model;
		end
		return word;
	endfunction

	// state change at one rising edge; rom and unmapped writes are dropped
	task automatic update_models();
		int unsigned idx;
		bit loaded;
		loaded = 1'b0;
		if (drw) begin
			if (daddr >= bus_pkg::RAM_BASE &&
			    daddr < bus_pkg::RAM_BASE + bus_pkg::RAM_WORDS * 4) begin
				idx = (daddr - bus_pkg::RAM_BASE) >> 2;
				ram_model[idx] = wdata;
				ram_valid[idx] = 1'b1;
			end else if (daddr == bus_pkg::IO_BASE + bus_pkg::IO_LEDS_OFS) begin
				led_model = wdata[7:0];
			end else if (daddr == bus_pkg::TIMER_BASE) begin
				timer_model = wdata;
				loaded = 1'b1;
			end
		end
		if (!loaded)
			timer_model = timer_model + 32'd1;
	endtask

	task automatic compare_word(input string what, input logic [31:0] got,
	                            input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_leds(input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0d ns: leds is %h, expected %h", $time, got, exp);
		end
	endtask

	// sample just before each rising edge, then advance the model
	always begin
		@(negedge clk);
		#(HALF_PERIOD - 1);
		if (rst_n) begin
			exp_inst = ref_read(iaddr, inst_known);
			exp_rdata = ref_read(daddr, rdata_known);
			if (inst_known)
				compare_word("inst", inst, exp_inst);
			if (rdata_known)
				compare_word("rdata", rdata, exp_rdata);
			compare_leds(leds, led_model);
		end
		@(posedge clk);
		if (rst_n)
			update_models();
	end

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------
	task automatic step(input int n);
		int done;
		realtime t0;
		done = 0;
		t0 = $realtime;
		while (done < n) begin
			@(negedge clk);
			done++;
			if ($realtime - t0 > (n + 2) * PERIOD) begin
				$display("timeout: the clock stalled while waiting %0d cycles", n);
				timed_out = 1'b1;
				break;
			end
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("test %0d %s finished with %0d errors", tests, name, errors - errs_mark);
		errs_mark = errors;
	endtask

	task automatic end_run();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	endtask

	// ----------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------
	initial begin : main
		int unsigned idx;
		int unsigned k;
		logic [31:0] outside [6];
		int unsigned written[$];

		void'($urandom(32'h644e_85ef));
		$readmemh("hw/rom_init.mem", rom_copy);
		led_model = '0;
		timer_model = '0;
		rst_n = 1'b0;
		iaddr = '0;
		daddr = '0;
		wdata = '0;
		drw = 1'b0;
		switches = '0;
		step(4);
		rst_n = 1'b1;

		// leds zero, timer counts from zero
		iaddr = bus_pkg::IO_BASE + bus_pkg::IO_LEDS_OFS;
		daddr = bus_pkg::TIMER_BASE;
		step(8);
		report_test("reset state");

		// rom on both ports, then a dropped write
		for (int i = 0; i < bus_pkg::ROM_WORDS; i++) begin
			iaddr = bus_pkg::ROM_BASE + 4 * i;
			daddr = bus_pkg::ROM_BASE + 4 * (bus_pkg::ROM_WORDS - 1 - i);
			step(1);
		end
		daddr = bus_pkg::ROM_BASE + 4 * 5;
		wdata = $urandom;
		drw = 1'b1;
		step(1);
		drw = 1'b0;
		for (int i = 0; i < bus_pkg::ROM_WORDS; i++) begin
			iaddr = bus_pkg::ROM_BASE + 4 * i;
			daddr = bus_pkg::ROM_BASE + 4 * i;
			step(1);
		end
		report_test("rom reads");

		// ram writes including first and last word
		iaddr = bus_pkg::ROM_BASE;
		for (int i = 0; i < 20; i++) begin
			if (i == 0)
				idx = 0;
			else if (i == 1)
				idx = bus_pkg::RAM_WORDS - 1;
			else
				idx = $urandom_range(bus_pkg::RAM_WORDS - 1, 0);
			written.push_back(idx);
			daddr = bus_pkg::RAM_BASE + 4 * idx;
			wdata = $urandom;
			drw = 1'b1;
			step(1);
		end
		drw = 1'b0;
		for (int j = 0; j < written.size(); j++) begin
			iaddr = bus_pkg::RAM_BASE + 4 * written[j];
			daddr = bus_pkg::RAM_BASE + 4 * written[written.size() - 1 - j];
			step(1);
		end
		report_test("ram write and read");

		// leds and switches
		switches = 8'($urandom);
		daddr = bus_pkg::IO_BASE + bus_pkg::IO_LEDS_OFS;
		wdata = $urandom;
		drw = 1'b1;
		step(1);
		drw = 1'b0;
		iaddr = bus_pkg::IO_BASE + bus_pkg::IO_SWITCHES_OFS;
		step(2);
		daddr = bus_pkg::IO_BASE + bus_pkg::IO_SWITCHES_OFS;
		wdata = $urandom;
		drw = 1'b1;
		step(1);
		drw = 1'b0;
		iaddr = bus_pkg::IO_BASE + bus_pkg::IO_LEDS_OFS;
		step(2);
		report_test("io block");

		// timer load then k cycles of reads
		iaddr = bus_pkg::TIMER_BASE;
		daddr = bus_pkg::TIMER_BASE;
		for (int i = 0; i < 3; i++) begin
			wdata = $urandom;
			drw = 1'b1;
			step(1);
			drw = 1'b0;
			k = $urandom_range(10, 1);
			step(k);
		end
		report_test("timer load");

		// unmapped addresses read zero and accept no write
		outside = '{32'h0000_0040, 32'h1000_0400, 32'hf020_0008,
		            32'hf060_0004, 32'h8000_0000, 32'hffff_fffc};
		for (int i = 0; i < 6; i++) begin
			iaddr = outside[i];
			daddr = outside[5 - i];
			wdata = $urandom;
			drw = 1'b1;
			step(1);
		end
		drw = 1'b0;
		iaddr = bus_pkg::RAM_BASE + 4 * written[0];
		daddr = bus_pkg::IO_BASE + bus_pkg::IO_LEDS_OFS;
		step(1);
		daddr = bus_pkg::TIMER_BASE;
		step(2);
		report_test("unmapped addresses");

		end_run();
	end

endmodule

`default_nettype wire

/* hw/rom_init.mem */
// one 32-bit word per line in hex, word 0 first, sixteen words
3c1d1000
27bdfffc
afbf0000
3c08f020
8d090004
ad090000
3c0af060
8d4b0000
01495021
ad4a0000
08000004
00000000
deadbeef
0badf00d
12345678
a5a5c3c3

/* compile.f */
hw/bus_pkg.sv
hw/addr_map.sv
hw/mod_rom.sv
hw/mod_ram.sv
hw/mod_io.sv
hw/mod_timer.sv
hw/arbiter.sv
test/tb_arbiter.sv

/* Bender.yml */
package:
  name: bus_arbiter

sources:
  - files:
      - hw/bus_pkg.sv
      - hw/addr_map.sv
      - hw/mod_rom.sv
      - hw/mod_ram.sv
      - hw/mod_io.sv
      - hw/mod_timer.sv
      - hw/arbiter.sv
  - target: test
    files:
      - test/tb_arbiter.sv
